/* rtl/ex_pkg.sv */
package ex_pkg;

    localparam int XLEN = 32; // Datapath width

    // ALU operation
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_op_e;

    // Operand format, selects the sources of ALU inputs a and b
    typedef enum logic [2:0] {
        MEM   = 3'd0, // rs1 + imm
        RR    = 3'd1, // rs1, rs2
        RI    = 3'd2, // rs1, imm
        LUI   = 3'd3, // imm, zero
        AUIPC = 3'd4, // pc, imm
        JAL   = 3'd5, // pc, 4
        JALR  = 3'd6  // pc, 4
    } opnd_sel_e;

    // Bit 3 marks a conditional branch, low bits follow funct3
    typedef enum logic [3:0] {
        BR_NONE  = 4'b0000,
        JUMP_PC  = 4'b0010,
        JUMP_REG = 4'b0011,
        BEQ      = 4'b1000,
        BNE      = 4'b1001,
        BLT      = 4'b1100,
        BGE      = 4'b1101,
        BLTU     = 4'b1110,
        BGEU     = 4'b1111
    } branch_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rs1_addr;
        logic [4:0]      rs2_addr;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [XLEN-1:0] imm;
        alu_op_e         alu_op;
        opnd_sel_e       opnd_sel;
        branch_e         branch;
        logic            mem_read;
        logic            mem_write;
        logic            reg_write;
        logic            mem_to_reg;
        logic [4:0]      rd;
    } id_ex_t;

    // Write-back forwarding source
    typedef struct packed {
        logic            reg_write;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } fwd_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] store_data;
        logic [4:0]      rd;
        logic            reg_write;
        logic            mem_read;
        logic            mem_write;
        logic            mem_to_reg;
    } ex_mem_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

/* rtl/ex_alu.sv */
module ex_alu (
    input  ex_pkg::alu_op_e         op,
    input  logic [ex_pkg::XLEN-1:0] a,
    input  logic [ex_pkg::XLEN-1:0] b,
    output logic [ex_pkg::XLEN-1:0] result,
    output logic                    eq,
    output logic                    lt,
    output logic                    ltu
);

    logic [4:0] shamt; // Shift amount from low bits of b

    assign shamt = b[4:0];

    // Flags do not depend on op, branches read them directly
    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb
    begin
        case (op)
            ex_pkg::ADD:    result = a + b;
            ex_pkg::SUB:    result = a - b;
            ex_pkg::SLL:    result = a << shamt;
            ex_pkg::SLT:    result = {{(ex_pkg::XLEN-1){1'b0}}, lt};
            ex_pkg::SLTU:   result = {{(ex_pkg::XLEN-1){1'b0}}, ltu};
            ex_pkg::XOR:    result = a ^ b;
            ex_pkg::SRL:    result = a >> shamt;
            ex_pkg::SRA:    result = $signed(a) >>> shamt; // Sign bit fills from the left
            ex_pkg::OR:     result = a | b;
            ex_pkg::AND:    result = a & b;
            ex_pkg::PASS_B: result = b;
            default:        result = '0;
        endcase
    end

endmodule

/* rtl/ex_operand_unit.sv */
module ex_operand_unit (
    input  ex_pkg::id_ex_t          id_ex,
    input  ex_pkg::ex_mem_t         ex_mem,
    input  ex_pkg::fwd_t            wb_fwd,
    input  ex_pkg::id_ex_t          cur,
    output logic [ex_pkg::XLEN-1:0] rs1_fwd,
    output logic [ex_pkg::XLEN-1:0] rs2_fwd,
    output logic [ex_pkg::XLEN-1:0] op_a,
    output logic [ex_pkg::XLEN-1:0] op_b
);

    // Own output first, then write-back, then register file value
    function automatic logic [ex_pkg::XLEN-1:0] fwd_pick(
        input logic [4:0]              addr,
        input logic [ex_pkg::XLEN-1:0] rf_val,
        input ex_pkg::ex_mem_t         own,
        input ex_pkg::fwd_t            wb
    );
        logic own_hit;
        logic wb_hit;
        own_hit = own.valid && own.reg_write && (own.rd != 5'd0) && (own.rd == addr);
        wb_hit  = wb.reg_write && (wb.rd != 5'd0) && (wb.rd == addr);
        if (own_hit)
            return own.alu_result;
        else if (wb_hit)
            return wb.data;
        else
            return rf_val;
    endfunction

    // Resolved on the incoming packet, stored at capture
    assign rs1_fwd = fwd_pick(id_ex.rs1_addr, id_ex.rs1_val, ex_mem, wb_fwd);
    assign rs2_fwd = fwd_pick(id_ex.rs2_addr, id_ex.rs2_val, ex_mem, wb_fwd);

    // Operand choice on the registered packet
    always_comb
    begin
        case (cur.opnd_sel)
            ex_pkg::MEM, ex_pkg::RI:
            begin
                op_a = cur.rs1_val;
                op_b = cur.imm;
            end
            ex_pkg::RR:
            begin
                op_a = cur.rs1_val;
                op_b = cur.rs2_val;
            end
            ex_pkg::LUI:
            begin
                op_a = cur.imm;
                op_b = '0;
            end
            ex_pkg::AUIPC:
            begin
                op_a = cur.pc;
                op_b = cur.imm;
            end
            ex_pkg::JAL, ex_pkg::JALR:
            begin
                op_a = cur.pc;              // Link value pc + 4
                op_b = ex_pkg::XLEN'(4);
            end
            default:
            begin
                op_a = '0;
                op_b = '0;
            end
        endcase
    end

endmodule

/* rtl/ex_branch_unit.sv */
module ex_branch_unit (
    input  ex_pkg::id_ex_t    cur,
    input  logic              eq,
    input  logic              lt,
    input  logic              ltu,
    output ex_pkg::redirect_t redirect
);

    logic                    cond;     // Branch condition before valid gating
    logic [ex_pkg::XLEN-1:0] reg_sum;  // rs1 + imm for register jumps

    assign reg_sum = cur.rs1_val + cur.imm;

    always_comb
    begin
        case (cur.branch)
            ex_pkg::BEQ:      cond = eq;
            ex_pkg::BNE:      cond = !eq;
            ex_pkg::BLT:      cond = lt;
            ex_pkg::BGE:      cond = !lt;
            ex_pkg::BLTU:     cond = ltu;
            ex_pkg::BGEU:     cond = !ltu;
            ex_pkg::JUMP_PC,
            ex_pkg::JUMP_REG: cond = 1'b1;
            default:          cond = 1'b0;
        endcase
    end

    assign redirect.taken = cur.valid && cond;

    // Register jumps clear bit 0, all others are pc relative
    always_comb
    begin
        if (cur.branch == ex_pkg::JUMP_REG)
            redirect.target = {reg_sum[ex_pkg::XLEN-1:1], 1'b0};
        else
            redirect.target = cur.pc + cur.imm;
    end

endmodule

/* rtl/ex_stage_ctrl.sv */
module ex_stage_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  ex_pkg::id_ex_t          id_ex,
    input  logic                    stall,
    input  logic [ex_pkg::XLEN-1:0] rs1_fwd,
    input  logic [ex_pkg::XLEN-1:0] rs2_fwd,
    input  logic [ex_pkg::XLEN-1:0] alu_result,
    output ex_pkg::id_ex_t          cur,
    output ex_pkg::ex_mem_t         ex_mem
);

    ex_pkg::id_ex_t next_pkt; // Incoming packet with forwarded operands

    always_comb
    begin
        next_pkt         = id_ex;
        next_pkt.rs1_val = rs1_fwd;
        next_pkt.rs2_val = rs2_fwd;
    end

    // ID/EX register, held while stalled
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cur <= '0;
        end
        else if (!stall)
        begin
            cur <= next_pkt;
        end
    end

    // EX/MEM packet
    always_comb
    begin
        ex_mem.valid      = cur.valid;
        ex_mem.alu_result = alu_result;
        ex_mem.store_data = cur.rs2_val;  // Already forwarded at capture
        ex_mem.rd         = cur.rd;

        // A bubble must not write anything downstream
        ex_mem.reg_write  = cur.valid && cur.reg_write;
        ex_mem.mem_read   = cur.valid && cur.mem_read;
        ex_mem.mem_write  = cur.valid && cur.mem_write;
        ex_mem.mem_to_reg = cur.valid && cur.mem_to_reg;
    end

endmodule

/* rtl/ex_top.sv */
module ex_top (
    input  logic              clk,
    input  logic              rst,
    input  ex_pkg::id_ex_t    id_ex,
    input  ex_pkg::fwd_t      wb_fwd,
    input  logic              stall,
    output ex_pkg::ex_mem_t   ex_mem,
    output ex_pkg::redirect_t redirect
);

    ex_pkg::id_ex_t          cur;      // Registered packet
    logic [ex_pkg::XLEN-1:0] rs1_fwd;
    logic [ex_pkg::XLEN-1:0] rs2_fwd;
    logic [ex_pkg::XLEN-1:0] op_a;
    logic [ex_pkg::XLEN-1:0] op_b;
    logic [ex_pkg::XLEN-1:0] alu_result;
    logic                    eq;
    logic                    lt;
    logic                    ltu;

    ex_stage_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .id_ex      (id_ex),
        .stall      (stall),
        .rs1_fwd    (rs1_fwd),
        .rs2_fwd    (rs2_fwd),
        .alu_result (alu_result),
        .cur        (cur),
        .ex_mem     (ex_mem)
    );

    ex_operand_unit u_opnd (
        .id_ex   (id_ex),
        .ex_mem  (ex_mem),   // Own output feeds back for forwarding
        .wb_fwd  (wb_fwd),
        .cur     (cur),
        .rs1_fwd (rs1_fwd),
        .rs2_fwd (rs2_fwd),
        .op_a    (op_a),
        .op_b    (op_b)
    );

    // Branches issue as RR, so flags compare rs1 against rs2
    ex_alu u_alu (
        .op     (cur.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result),
        .eq     (eq),
        .lt     (lt),
        .ltu    (ltu)
    );

    ex_branch_unit u_branch (
        .cur      (cur),
        .eq       (eq),
        .lt       (lt),
        .ltu      (ltu),
        .redirect (redirect)
    );

endmodule

/* testbench/tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk; // Period of 8
    end

    // Reset held over four rising edges
    initial
    begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* testbench/ex_assert.sv */
module ex_assert (
    input logic              clk,
    input logic              rst,
    input logic              stall,
    input ex_pkg::id_ex_t    id_ex,
    input ex_pkg::ex_mem_t   ex_mem,
    input ex_pkg::redirect_t redirect
);

    int fail_count = 0; // Read by the testbench at the end of the run

    // Reset empties the stage
    a_reset_clear: assert property (@(posedge clk) rst |=> !ex_mem.valid)
    else
    begin
        $error("ex_mem.valid high while in reset");
        fail_count++;
    end

    // A stalled edge leaves both output packets untouched
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(ex_mem) && $stable(redirect))
    else
    begin
        $error("Outputs changed across a stalled edge");
        fail_count++;
    end

    // A bubble captured at issue never redirects in the next cycle
    a_taken_valid: assert property (@(posedge clk) disable iff (rst)
        (!stall && !id_ex.valid) |=> !redirect.taken)
    else
    begin
        $error("Redirect taken for an invalid packet");
        fail_count++;
    end

endmodule

/* testbench/ex_tb.sv */
module ex_tb;

    localparam int NROWS = 33;
    localparam int LIMIT = 4 * NROWS + 20; // Cycle budget for the whole run

    logic              clk;
    logic              rst;
    ex_pkg::id_ex_t    id_ex;
    ex_pkg::fwd_t      wb_fwd;
    logic              stall;
    ex_pkg::ex_mem_t   ex_mem;
    ex_pkg::redirect_t redirect;

    // Stimulus and expected values, one entry per row
    ex_pkg::id_ex_t pkts [NROWS];
    ex_pkg::fwd_t   wbs [NROWS];
    logic           stalls [NROWS];
    logic [31:0]    exp_res [NROWS];
    logic           exp_tk [NROWS];
    logic [31:0]    exp_tgt [NROWS];

    int     nrows = 0;
    int     checks = 0;
    int     errors = 0;
    int     cycles = 0;
    logic   row_ok;
    integer seed = 32'h885f;

    tb_clk_gen clk_gen (
        .clk (clk),
        .rst (rst)
    );

    ex_top UUT (
        .clk      (clk),
        .rst      (rst),
        .id_ex    (id_ex),
        .wb_fwd   (wb_fwd),
        .stall    (stall),
        .ex_mem   (ex_mem),
        .redirect (redirect)
    );

    bind ex_top ex_assert u_assert (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .redirect (redirect)
    );

    task automatic add_row(
        input ex_pkg::alu_op_e op, input ex_pkg::opnd_sel_e sel, input ex_pkg::branch_e br,
        input logic [31:0] pc, input logic [31:0] imm,
        input logic [4:0] rs1, input logic [31:0] rs1_val,
        input logic [4:0] rs2, input logic [31:0] rs2_val,
        input logic [4:0] rd, input logic [31:0] res,
        input logic taken, input logic [31:0] target
    );
        ex_pkg::id_ex_t p;
        p           = '0;
        p.valid     = 1'b1;
        p.pc        = pc;
        p.imm       = imm;
        p.rs1_addr  = rs1;
        p.rs1_val   = rs1_val;
        p.rs2_addr  = rs2;
        p.rs2_val   = rs2_val;
        p.alu_op    = op;
        p.opnd_sel  = sel;
        p.branch    = br;
        p.rd        = rd;
        p.reg_write = 1'b1;
        pkts[nrows]    = p;
        wbs[nrows]     = '0;
        stalls[nrows]  = 1'b0;
        exp_res[nrows] = res;
        exp_tk[nrows]  = taken;
        exp_tgt[nrows] = target;
        nrows++;
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        // op, format, branch, pc, imm, rs1, value, rs2, value, rd, result, taken, target
        add_row(ex_pkg::ADD, ex_pkg::RR, ex_pkg::BR_NONE, 0, 0, 1, 100, 2, 23, 5, 123, 0, 0);
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BR_NONE, 0, 0, 5, 0, 3, 200, 6, -77, 0, 0);
        add_row(ex_pkg::SRA, ex_pkg::RI, ex_pkg::BR_NONE, 0, 4, 7, 'h80000010, 0, 0, 8,
                'hf8000001, 0, 0);
        add_row(ex_pkg::SLT, ex_pkg::RR, ex_pkg::BR_NONE, 0, 0, 9, -1, 10, 1, 11, 1, 0, 0);
        add_row(ex_pkg::SLTU, ex_pkg::RR, ex_pkg::BR_NONE, 0, 0, 9, -1, 10, 1, 12, 0, 0, 0);
        add_row(ex_pkg::ADD, ex_pkg::RI, ex_pkg::BR_NONE, 0, 5, 20, 0, 0, 0, 21, 'h1005, 0, 0);
        wbs[nrows-1] = '{1'b1, 5'd20, 32'h1000};
        // Own output and write-back both hold x21
        add_row(ex_pkg::ADD, ex_pkg::RR, ex_pkg::BR_NONE, 0, 0, 21, 0, 22, 10, 0, 'h100f, 0, 0);
        wbs[nrows-1] = '{1'b1, 5'd21, 32'hdead};
        add_row(ex_pkg::ADD, ex_pkg::RR, ex_pkg::BR_NONE, 0, 0, 0, 0, 2, 3, 24, 3, 0, 0);
        wbs[nrows-1] = '{1'b1, 5'd0, 32'h55};
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BEQ, 'h100, 'h20, 1, 5, 2, 5, 0, 0, 1, 'h120);
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BNE, 'h104, 'h20, 1, 5, 2, 5, 0, 0, 0, 0);
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BLT, 'h200, -8, 1, -5, 2, 3, 0, -8, 1, 'h1f8);
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BGE, 'h204, -8, 1, -5, 2, 3, 0, -8, 0, 0);
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BLTU, 'h208, -8, 1, -5, 2, 3, 0, -8, 0, 0);
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BGEU, 'h300, 'h10, 1, -5, 2, 3, 0, -8, 1, 'h310);
        // Same six conditions in the opposite direction
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BNE, 'h108, 'h20, 1, 5, 2, 6, 0, -1, 1, 'h128);
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BEQ, 'h10c, 'h20, 1, 5, 2, 6, 0, -1, 0, 0);
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BGE, 'h20c, -8, 1, 3, 2, -5, 0, 8, 1, 'h204);
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BLT, 'h210, -8, 1, 3, 2, -5, 0, 8, 0, 0);
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BLTU, 'h304, 'h10, 1, 3, 2, -5, 0, 8, 1, 'h314);
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BGEU, 'h308, 'h10, 1, 3, 2, -5, 0, 8, 0, 0);
        add_row(ex_pkg::ADD, ex_pkg::JAL, ex_pkg::JUMP_PC, 'h400, 'h800, 0, 0, 0, 0, 1,
                'h404, 1, 'hc00);
        add_row(ex_pkg::ADD, ex_pkg::JALR, ex_pkg::JUMP_REG, 'h500, 'h10, 3, 'h1001, 0, 0, 25,
                'h504, 1, 'h1010);
        add_row(ex_pkg::ADD, ex_pkg::LUI, ex_pkg::BR_NONE, 0, 'h12345000, 0, 0, 0, 0, 26,
                'h12345000, 0, 0);
        add_row(ex_pkg::ADD, ex_pkg::AUIPC, ex_pkg::BR_NONE, 'h600, 'h1000, 0, 0, 0, 0, 27,
                'h1600, 0, 0);
        add_row(ex_pkg::ADD, ex_pkg::MEM, ex_pkg::BR_NONE, 0, 8, 4, 'h2000, 28, 'hcafebabe, 0,
                'h2008, 0, 0);
        pkts[nrows-1].reg_write = 1'b0; // Store
        pkts[nrows-1].mem_write = 1'b1;
        add_row(ex_pkg::ADD, ex_pkg::MEM, ex_pkg::BR_NONE, 0, 4, 4, 'h3000, 0, 0, 29,
                'h3004, 0, 0);
        pkts[nrows-1].mem_read   = 1'b1; // Load
        pkts[nrows-1].mem_to_reg = 1'b1;
        add_row(ex_pkg::ADD, ex_pkg::RI, ex_pkg::JUMP_PC, 0, 1, 1, 1, 0, 0, 9, 2, 0, 0);
        pkts[nrows-1].valid     = 1'b0;
        pkts[nrows-1].mem_read  = 1'b1;
        pkts[nrows-1].mem_write = 1'b1;
        add_row(ex_pkg::ADD, ex_pkg::RR, ex_pkg::BR_NONE, 0, 0, 1, 40, 2, 2, 30, 42, 0, 0);
        // Dependent SUB waits one stalled cycle, then issues
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BR_NONE, 0, 0, 30, 0, 2, 2, 31, 40, 0, 0);
        stalls[nrows-1] = 1'b1;
        add_row(ex_pkg::SUB, ex_pkg::RR, ex_pkg::BR_NONE, 0, 0, 30, 0, 2, 2, 31, 40, 0, 0);
        a = $random(seed);
        b = $random(seed);
        add_row(ex_pkg::ADD, ex_pkg::RR, ex_pkg::BR_NONE, 0, 0, 16, a, 17, b, 18, a + b, 0, 0);
        a = $random(seed);
        b = $random(seed);
        add_row(ex_pkg::XOR, ex_pkg::RR, ex_pkg::BR_NONE, 0, 0, 16, a, 17, b, 19, a ^ b, 0, 0);
        a = $random(seed);
        b = $random(seed);
        add_row(ex_pkg::SRL, ex_pkg::RR, ex_pkg::BR_NONE, 0, 0, 16, a, 17, b, 15,
                a >> b[4:0], 0, 0);
    endtask

    task automatic drive_row(input int i);
        id_ex  <= pkts[i];
        wb_fwd <= wbs[i];
        stall  <= stalls[i];
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("Fail at %0t: %s got %h, expected %h", $time, name, got, exp);
            errors++;
            row_ok = 1'b0;
        end
    endtask

    task automatic check_row(input int i);
        int             j;
        ex_pkg::id_ex_t p;
        logic [4:0]     ctl;
        j   = stalls[i] ? i - 1 : i; // Stalled cycle repeats the held instruction
        p   = pkts[j];
        ctl = {p.valid, p.valid & p.reg_write, p.valid & p.mem_read, p.valid & p.mem_write,
               p.valid & p.mem_to_reg};
        row_ok = 1'b1;
        check_val("ex_mem.alu_result", ex_mem.alu_result, exp_res[j]);
        check_val("ex_mem.rd", ex_mem.rd, p.rd);
        check_val("ex_mem controls", {ex_mem.valid, ex_mem.reg_write, ex_mem.mem_read,
                  ex_mem.mem_write, ex_mem.mem_to_reg}, ctl);
        check_val("redirect.taken", redirect.taken, exp_tk[j]);
        if (exp_tk[j])
            check_val("redirect.target", redirect.target, exp_tgt[j]);
        if (p.mem_write)
            check_val("ex_mem.store_data", ex_mem.store_data, p.rs2_val);
        $display("Row %0d %s", i, row_ok ? "passed" : "failed");
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT)
        begin
            $display("Timeout, run did not finish within %0d cycles", LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial
    begin
        id_ex  = '0;
        wb_fwd = '0;
        stall  = 1'b0;
        build_table();
        @(negedge rst);
        @(negedge clk);
        row_ok = 1'b1;
        check_val("ex_mem controls", {ex_mem.valid, ex_mem.reg_write, ex_mem.mem_read,
                  ex_mem.mem_write}, 0);
        check_val("redirect.taken", redirect.taken, 0);
        $display("Reset state %s", row_ok ? "passed" : "failed");
        @(posedge clk);
        drive_row(0);
        for (int i = 0; i < nrows; i++)
        begin
            @(posedge clk);
            if (i + 1 < nrows)
                drive_row(i + 1);
            else
                id_ex <= '0; // Bubble after the last row
            @(negedge clk);
            check_row(i);
        end
        errors += UUT.u_assert.fail_count;
        $display("Rows %0d, checks %0d, errors %0d, assertion failures %0d",
                 nrows, checks, errors, UUT.u_assert.fail_count);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* tb.f */
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_operand_unit.sv
rtl/ex_branch_unit.sv
rtl/ex_stage_ctrl.sv
rtl/ex_top.sv
testbench/tb_clk_gen.sv
testbench/ex_assert.sv
testbench/ex_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - rtl/ex_pkg.sv
  - rtl/ex_alu.sv
  - rtl/ex_operand_unit.sv
  - rtl/ex_branch_unit.sv
  - rtl/ex_stage_ctrl.sv
  - rtl/ex_top.sv
  - target: simulation
    files:
      - testbench/tb_clk_gen.sv
      - testbench/ex_assert.sv
      - testbench/ex_tb.sv
